// File: common/pwmPkg.sv
`default_nettype none

package pwmPkg;

	// peripheral bus widths
	typedef logic [15:0] busAddr_t;
	typedef logic [11:0] localAddr_t;
	typedef logic [31:0] busData_t;
	typedef logic [3:0] byteSel_t;
	typedef logic [3:0] deviceId_t;

	// prescale shift, one clock tick every 2^scale cycles
	localparam int PRESCALE_BITS = 5;
	typedef logic [PRESCALE_BITS-1:0] prescale_t;

	// one bus request as seen by every device
	typedef struct packed {
		logic we;
		logic oe;
		busAddr_t address;
		byteSel_t byteSelect;
		busData_t dataWrite;
	} busRequest_t;

	// registered read response
	typedef struct packed {
		logic requestOutput;
		busData_t dataRead;
	} busResponse_t;

	// timebase control, low bits of the configuration word
	typedef struct packed {
		logic counterEnable;
		prescale_t clockScale;
	} timebaseConfig_t;

	// register offsets inside one device
	localparam localAddr_t CONFIG_OFFSET = 12'h000;
	localparam localAddr_t TOP_OFFSET = 12'h004;
	localparam localAddr_t STATUS_OFFSET = 12'h008;
	// channel i compare at COMPARE_BASE + 4*i
	localparam localAddr_t COMPARE_BASE = 12'h010;

	// reset values
	localparam prescale_t DEFAULT_SCALE = 5'd3;
	localparam logic [15:0] DEFAULT_TOP = 16'h1388;

endpackage

`default_nettype wire

// File: pwm/pwmChannel.sv
`timescale 1ns/1ps
`default_nettype none

module pwmChannel #(
	parameter int WIDTH = 16
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic enable,
	input wire logic [WIDTH-1:0] compareValue,
	input wire logic [WIDTH-1:0] counterValue,
	output logic pwmOut,
	output logic rise,
	output logic fall
);

	logic outLevel;
	logic lastLevel;
	logic compareHit;

	// high while the counter sits below compare
	assign compareHit = enable && (counterValue < compareValue);

	always_ff @(posedge clk) begin
		if (rst) begin
			outLevel <= 1'b0;
			lastLevel <= 1'b0;
		end else begin
			outLevel <= compareHit;
			lastLevel <= outLevel;
		end
	end

	assign pwmOut = outLevel;

	// edges show in the first cycle of the new level
	assign rise = outLevel && !lastLevel;
	assign fall = !outLevel && lastLevel;

	// switching a high channel off gives a fall next cycle
	assert property (@(posedge clk) disable iff (rst)
		pwmOut && !enable |=> fall);

endmodule

`default_nettype wire

// File: pwm/pwmTimebase.sv
`timescale 1ns/1ps
`default_nettype none

module pwmTimebase #(
	parameter int WIDTH = 16
) (
	input wire logic clk,
	input wire logic rst,
	input wire pwmPkg::timebaseConfig_t cfg,
	input wire logic [WIDTH-1:0] top,
	input wire logic topWrite,
	output logic [WIDTH-1:0] counterValue
);

	// prescaler spans up to 2^31 cycles per tick
	localparam int PRESCALE_COUNT_BITS = 31;

	typedef logic [WIDTH-1:0] count_t;
	typedef logic [PRESCALE_COUNT_BITS-1:0] prescaleCount_t;

	prescaleCount_t prescaleCount;
	prescaleCount_t lastCount;
	logic tick;
	count_t counter;

	// 2^scale - 1, scale 31 wraps to all ones
	assign lastCount = (prescaleCount_t'(1) << cfg.clockScale) - prescaleCount_t'(1);
	// a lowered scale ends the running count at once
	assign tick = (prescaleCount >= lastCount);

	always_ff @(posedge clk) begin
		if (rst || !cfg.counterEnable || topWrite) begin
			prescaleCount <= '0;
			counter <= '0;
		end else if (tick) begin
			prescaleCount <= '0;
			if (counter == top) begin
				counter <= '0;
			end else begin
				counter <= counter + count_t'(1);
			end
		end else begin
			prescaleCount <= prescaleCount + prescaleCount_t'(1);
		end
	end

	assign counterValue = counter;

	// a new top may sit below the counter for its write cycle only
	assert property (@(posedge clk) disable iff (rst)
		!topWrite |-> counterValue <= top);

endmodule

`default_nettype wire

// File: pwm/pwmRegisters.sv
`timescale 1ns/1ps
`default_nettype none

module pwmRegisters #(
	parameter pwmPkg::deviceId_t ID = 4'h0,
	parameter int OUTPUTS = 4,
	parameter int WIDTH = 16
) (
	input wire logic clk,
	input wire logic rst,

	input wire logic peripheralEnable,
	input wire pwmPkg::busRequest_t bus,
	output pwmPkg::busResponse_t response,

	output pwmPkg::timebaseConfig_t timebaseCfg,
	output logic [WIDTH-1:0] top,
	output logic topWrite,
	output logic [OUTPUTS*WIDTH-1:0] compareValues,
	output logic [OUTPUTS-1:0] compareEnable,
	output logic [OUTPUTS-1:0] pwmEn,

	input wire logic [WIDTH-1:0] counterValue,
	input wire logic [OUTPUTS-1:0] pwmOut,
	input wire logic [OUTPUTS-1:0] rise,
	input wire logic [OUTPUTS-1:0] fall,
	output logic pwmIrq
);

	// scale, counter enable, then four enable fields per channel
	localparam int FIELD_BASE = pwmPkg::PRESCALE_BITS + 1;
	localparam int CFG_W = FIELD_BASE + 4 * OUTPUTS;

	typedef logic [WIDTH-1:0] count_t;
	typedef logic [CFG_W-1:0] config_t;
	typedef logic [OUTPUTS-1:0] chanMask_t;

	pwmPkg::localAddr_t localAddr;
	logic deviceSel;
	logic writeAccess;
	logic readAccess;

	config_t configReg;
	count_t topReg;
	count_t compareReg [OUTPUTS];

	chanMask_t outputEnable;
	chanMask_t riseIrqEnable;
	chanMask_t fallIrqEnable;

	logic readHit;
	pwmPkg::busData_t readValue;

	// keep the old byte wherever its select bit is low
	function automatic pwmPkg::busData_t mergeBytes(input pwmPkg::busData_t oldValue,
			input pwmPkg::busData_t newValue, input pwmPkg::byteSel_t sel);
		pwmPkg::busData_t merged;
		merged = oldValue;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				merged[8*b +: 8] = newValue[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// device select on the upper address nibble
	assign deviceSel = peripheralEnable && (bus.address[15:12] == ID);
	assign localAddr = bus.address[11:0];
	assign writeAccess = deviceSel && bus.we;
	assign readAccess = deviceSel && bus.oe;

	always_ff @(posedge clk) begin
		if (rst) begin
			configReg <= config_t'(pwmPkg::DEFAULT_SCALE);
			topReg <= count_t'(pwmPkg::DEFAULT_TOP);
			topWrite <= 1'b0;
			for (int i = 0; i < OUTPUTS; i++) begin
				compareReg[i] <= '0;
			end
		end else begin
			topWrite <= writeAccess && (localAddr == pwmPkg::TOP_OFFSET);
			if (writeAccess) begin
				if (localAddr == pwmPkg::CONFIG_OFFSET) begin
					configReg <= config_t'(mergeBytes(pwmPkg::busData_t'(configReg),
						bus.dataWrite, bus.byteSelect));
				end
				if (localAddr == pwmPkg::TOP_OFFSET) begin
					topReg <= count_t'(mergeBytes(pwmPkg::busData_t'(topReg),
						bus.dataWrite, bus.byteSelect));
				end
				for (int i = 0; i < OUTPUTS; i++) begin
					if (localAddr == pwmPkg::COMPARE_BASE + pwmPkg::localAddr_t'(4 * i)) begin
						compareReg[i] <= count_t'(mergeBytes(pwmPkg::busData_t'(compareReg[i]),
							bus.dataWrite, bus.byteSelect));
					end
				end
			end
		end
	end

	// read mux, status is read only
	always_comb begin
		readHit = 1'b0;
		readValue = '0;
		case (localAddr)
			pwmPkg::CONFIG_OFFSET: begin
				readHit = 1'b1;
				readValue = pwmPkg::busData_t'(configReg);
			end
			pwmPkg::TOP_OFFSET: begin
				readHit = 1'b1;
				readValue = pwmPkg::busData_t'(topReg);
			end
			pwmPkg::STATUS_OFFSET: begin
				readHit = 1'b1;
				readValue = pwmPkg::busData_t'({pwmOut, counterValue});
			end
			default: begin
			end
		endcase
		for (int i = 0; i < OUTPUTS; i++) begin
			if (localAddr == pwmPkg::COMPARE_BASE + pwmPkg::localAddr_t'(4 * i)) begin
				readHit = 1'b1;
				readValue = pwmPkg::busData_t'(compareReg[i]);
			end
		end
	end

	// response one clock after the read strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			response <= '0;
		end else begin
			response.requestOutput <= readAccess && readHit;
			response.dataRead <= (readAccess && readHit) ? readValue : '0;
		end
	end

	// configuration fields
	assign timebaseCfg.clockScale = configReg[pwmPkg::PRESCALE_BITS-1:0];
	assign timebaseCfg.counterEnable = configReg[pwmPkg::PRESCALE_BITS];
	assign compareEnable = configReg[FIELD_BASE +: OUTPUTS];
	assign outputEnable = configReg[FIELD_BASE + OUTPUTS +: OUTPUTS];
	assign riseIrqEnable = configReg[FIELD_BASE + 2 * OUTPUTS +: OUTPUTS];
	assign fallIrqEnable = configReg[FIELD_BASE + 3 * OUTPUTS +: OUTPUTS];

	assign top = topReg;

	always_comb begin
		for (int i = 0; i < OUTPUTS; i++) begin
			compareValues[i*WIDTH +: WIDTH] = compareReg[i];
		end
	end

	assign pwmEn = compareEnable & outputEnable;

	// any enabled edge on any channel
	assign pwmIrq = |((rise & riseIrqEnable) | (fall & fallIrqEnable));

	// a response only ever answers a read from the cycle before
	assert property (@(posedge clk) disable iff (rst)
		response.requestOutput |-> $past(readAccess));

	// timebase restart is a single pulse
	assert property (@(posedge clk) disable iff (rst)
		topWrite |=> !topWrite);

endmodule

`default_nettype wire

// File: design/pwmPeripheral.sv
`timescale 1ns/1ps
`default_nettype none

module pwmPeripheral #(
	parameter pwmPkg::deviceId_t ID = 4'h0,
	parameter int OUTPUTS = 4,
	parameter int WIDTH = 16
) (
	input wire logic clk,
	input wire logic rst,

	input wire logic peripheralEnable,
	input wire pwmPkg::busRequest_t bus,
	output pwmPkg::busResponse_t response,

	output logic [OUTPUTS-1:0] pwmEn,
	output logic [OUTPUTS-1:0] pwmOut,
	output logic pwmIrq
);

	pwmPkg::timebaseConfig_t timebaseCfg;
	logic [WIDTH-1:0] top;
	logic topWrite;
	logic [OUTPUTS*WIDTH-1:0] compareValues;
	logic [OUTPUTS-1:0] compareEnable;
	logic [WIDTH-1:0] counterValue;
	logic [OUTPUTS-1:0] rise;
	logic [OUTPUTS-1:0] fall;

	// bus registers and interrupt
	pwmRegisters #(
		.ID(ID),
		.OUTPUTS(OUTPUTS),
		.WIDTH(WIDTH)
	) registersInst (
		.clk(clk),
		.rst(rst),
		.peripheralEnable(peripheralEnable),
		.bus(bus),
		.response(response),
		.timebaseCfg(timebaseCfg),
		.top(top),
		.topWrite(topWrite),
		.compareValues(compareValues),
		.compareEnable(compareEnable),
		.pwmEn(pwmEn),
		.counterValue(counterValue),
		.pwmOut(pwmOut),
		.rise(rise),
		.fall(fall),
		.pwmIrq(pwmIrq)
	);

	// shared counter for all channels
	pwmTimebase #(
		.WIDTH(WIDTH)
	) timebaseInst (
		.clk(clk),
		.rst(rst),
		.cfg(timebaseCfg),
		.top(top),
		.topWrite(topWrite),
		.counterValue(counterValue)
	);

	for (genvar i = 0; i < OUTPUTS; i++) begin : gChannel
		pwmChannel #(
			.WIDTH(WIDTH)
		) channelInst (
			.clk(clk),
			.rst(rst),
			.enable(compareEnable[i]),
			.compareValue(compareValues[i*WIDTH +: WIDTH]),
			.counterValue(counterValue),
			.pwmOut(pwmOut[i]),
			.rise(rise[i]),
			.fall(fall[i])
		);
	end

endmodule

`default_nettype wire

// File: tb/pwmPeripheralTb.sv
`timescale 1ns/1ps
`default_nettype none

module pwmPeripheralTb;

	localparam pwmPkg::deviceId_t ID = 4'h5;
	localparam int OUTPUTS = 4;
	localparam int WIDTH = 8;
	localparam int CFG_W = 6 + 4 * OUTPUTS;
	localparam int IDX_W = $clog2(OUTPUTS);
	localparam int TIMEOUT_CYCLES = 20000;
	// default top cut down to the counter width
	localparam logic [WIDTH-1:0] TOP_RESET = WIDTH'(pwmPkg::DEFAULT_TOP);

	logic clk = 1'b0;
	logic rst;
	logic peripheralEnable;
	pwmPkg::busRequest_t bus;
	pwmPkg::busResponse_t response;
	logic [OUTPUTS-1:0] pwmEn;
	logic [OUTPUTS-1:0] pwmOut;
	logic pwmIrq;

	integer seed;
	logic [31:0] randomWord;
	int cycleCount = 0;

	// reference model state
	logic [CFG_W-1:0] mConfig;
	logic [WIDTH-1:0] mTop;
	logic [WIDTH-1:0] mCompare [OUTPUTS];
	logic mTopWrite;
	logic [31:0] mPrescale;
	logic [WIDTH-1:0] mCounter;
	logic [OUTPUTS-1:0] mOut;
	logic [OUTPUTS-1:0] mPrevOut;
	logic expReq;
	pwmPkg::busData_t expData;
	logic [OUTPUTS-1:0] expEn;
	logic expIrq;

	logic deviceAccess;
	pwmPkg::localAddr_t offs;
	pwmPkg::localAddr_t chanOffset;
	logic compareSel;
	logic [IDX_W-1:0] compareIdx;
	logic modelHit;
	pwmPkg::busData_t modelValue;

	pwmPeripheral #(
		.ID(ID),
		.OUTPUTS(OUTPUTS),
		.WIDTH(WIDTH)
	) pwmPeripheral_inst (
		.clk(clk),
		.rst(rst),
		.peripheralEnable(peripheralEnable),
		.bus(bus),
		.response(response),
		.pwmEn(pwmEn),
		.pwmOut(pwmOut),
		.pwmIrq(pwmIrq)
	);

	always #10 clk = ~clk;

	task stopWithFailure();
		$display("Checks failed");
		$fatal(1);
	endtask

	task reportMismatch(input string name, input logic [31:0] expected, input logic [31:0] actual);
		$display("FAILED at %0t: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
		stopWithFailure();
	endtask

	function automatic pwmPkg::busData_t applyByteMask(input pwmPkg::busData_t oldWord,
			input pwmPkg::busData_t newWord, input pwmPkg::byteSel_t sel);
		pwmPkg::busData_t mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (oldWord & ~mask) | (newWord & mask);
	endfunction

	function automatic pwmPkg::busAddr_t deviceAddr(input pwmPkg::localAddr_t offset);
		return {ID, offset};
	endfunction

	function automatic pwmPkg::busData_t makeConfig(input pwmPkg::prescale_t scale, input logic en,
			input logic [OUTPUTS-1:0] cmpEn, input logic [OUTPUTS-1:0] outEn,
			input logic [OUTPUTS-1:0] riseEn, input logic [OUTPUTS-1:0] fallEn);
		pwmPkg::busData_t word;
		word = '0;
		word[4:0] = scale;
		word[5] = en;
		word[6 +: OUTPUTS] = cmpEn;
		word[6 + OUTPUTS +: OUTPUTS] = outEn;
		word[6 + 2 * OUTPUTS +: OUTPUTS] = riseEn;
		word[6 + 3 * OUTPUTS +: OUTPUTS] = fallEn;
		return word;
	endfunction

	// one bus cycle, driven between falling edges
	task automatic busAccess(input logic en, input pwmPkg::busAddr_t addr, input logic we,
			input logic oe, input pwmPkg::busData_t data, input pwmPkg::byteSel_t sel);
		@(negedge clk);
		peripheralEnable = en;
		bus.we = we;
		bus.oe = oe;
		bus.address = addr;
		bus.byteSelect = sel;
		bus.dataWrite = data;
		@(negedge clk);
		peripheralEnable = 1'b0;
		bus = '0;
	endtask

	task automatic writeReg(input pwmPkg::localAddr_t offset, input pwmPkg::busData_t data,
			input pwmPkg::byteSel_t sel);
		busAccess(1'b1, deviceAddr(offset), 1'b1, 1'b0, data, sel);
	endtask

	task automatic readReg(input pwmPkg::localAddr_t offset);
		busAccess(1'b1, deviceAddr(offset), 1'b0, 1'b1, '0, '0);
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic readAllRegisters();
		readReg(pwmPkg::CONFIG_OFFSET);
		readReg(pwmPkg::TOP_OFFSET);
		readReg(pwmPkg::STATUS_OFFSET);
		for (int i = 0; i < OUTPUTS; i++) begin
			readReg(pwmPkg::COMPARE_BASE + pwmPkg::localAddr_t'(4 * i));
		end
	endtask

	// decode of the current request against the model registers
	always_comb begin
		deviceAccess = peripheralEnable && (bus.address[15:12] == ID);
		offs = bus.address[11:0];
		chanOffset = offs - pwmPkg::COMPARE_BASE;
		compareSel = (offs >= pwmPkg::COMPARE_BASE) && (chanOffset[1:0] == 2'b00)
			&& (chanOffset[11:2] < 10'(OUTPUTS));
		compareIdx = chanOffset[2 +: IDX_W];
		modelHit = 1'b1;
		modelValue = '0;
		if (offs == pwmPkg::CONFIG_OFFSET) begin
			modelValue = 32'(mConfig);
		end else if (offs == pwmPkg::TOP_OFFSET) begin
			modelValue = 32'(mTop);
		end else if (offs == pwmPkg::STATUS_OFFSET) begin
			modelValue = 32'({mOut, mCounter});
		end else if (compareSel) begin
			modelValue = 32'(mCompare[compareIdx]);
		end else begin
			modelHit = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			mConfig <= CFG_W'(pwmPkg::DEFAULT_SCALE);
			mTop <= TOP_RESET;
			for (int i = 0; i < OUTPUTS; i++) begin
				mCompare[i] <= '0;
			end
			mTopWrite <= 1'b0;
			mPrescale <= '0;
			mCounter <= '0;
			mOut <= '0;
			mPrevOut <= '0;
			expReq <= 1'b0;
			expData <= '0;
		end else begin
			mTopWrite <= deviceAccess && bus.we && (offs == pwmPkg::TOP_OFFSET);
			if (deviceAccess && bus.we) begin
				if (offs == pwmPkg::CONFIG_OFFSET) begin
					mConfig <= CFG_W'(applyByteMask(32'(mConfig), bus.dataWrite, bus.byteSelect));
				end else if (offs == pwmPkg::TOP_OFFSET) begin
					mTop <= WIDTH'(applyByteMask(32'(mTop), bus.dataWrite, bus.byteSelect));
				end else if (compareSel) begin
					mCompare[compareIdx] <= WIDTH'(applyByteMask(32'(mCompare[compareIdx]),
						bus.dataWrite, bus.byteSelect));
				end
			end
			expReq <= deviceAccess && bus.oe && modelHit;
			expData <= (deviceAccess && bus.oe && modelHit) ? modelValue : 32'd0;
			// prescaler runs 0 to 2^scale-1, counter steps on the last count
			if (!mConfig[5] || mTopWrite) begin
				mPrescale <= '0;
				mCounter <= '0;
			end else if (mPrescale >= (32'd1 << mConfig[4:0]) - 32'd1) begin
				mPrescale <= '0;
				mCounter <= (mCounter == mTop) ? '0 : mCounter + WIDTH'(1);
			end else begin
				mPrescale <= mPrescale + 32'd1;
			end
			for (int i = 0; i < OUTPUTS; i++) begin
				mOut[i] <= mConfig[6 + i] && (mCounter < mCompare[i]);
			end
			mPrevOut <= mOut;
		end
	end

	assign expEn = mConfig[6 +: OUTPUTS] & mConfig[6 + OUTPUTS +: OUTPUTS];
	assign expIrq = |((mOut & ~mPrevOut & mConfig[6 + 2 * OUTPUTS +: OUTPUTS])
		| (~mOut & mPrevOut & mConfig[6 + 3 * OUTPUTS +: OUTPUTS]));

	assert property (@(posedge clk) disable iff (rst) response.requestOutput == expReq)
	else reportMismatch("response.requestOutput", 32'($sampled(expReq)),
		32'($sampled(response.requestOutput)));

	assert property (@(posedge clk) disable iff (rst) response.dataRead == expData)
	else reportMismatch("response.dataRead", $sampled(expData), $sampled(response.dataRead));

	assert property (@(posedge clk) disable iff (rst) pwmOut == mOut)
	else reportMismatch("pwmOut", 32'($sampled(mOut)), 32'($sampled(pwmOut)));

	assert property (@(posedge clk) disable iff (rst) pwmEn == expEn)
	else reportMismatch("pwmEn", 32'($sampled(expEn)), 32'($sampled(pwmEn)));

	assert property (@(posedge clk) disable iff (rst) pwmIrq == expIrq)
	else reportMismatch("pwmIrq", 32'($sampled(expIrq)), 32'($sampled(pwmIrq)));

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == TIMEOUT_CYCLES) begin
			$display("simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
			stopWithFailure();
		end
	end

	initial begin
		seed = 47;
		rst = 1'b1;
		peripheralEnable = 1'b0;
		bus = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// reset values
		readAllRegisters();
		waitCycles(4);

		// byte masked writes
		writeReg(pwmPkg::CONFIG_OFFSET, 32'hffff_ffff, 4'b0100);
		readReg(pwmPkg::CONFIG_OFFSET);
		writeReg(pwmPkg::CONFIG_OFFSET, 32'h00c3_a5c2, 4'b0010);
		readReg(pwmPkg::CONFIG_OFFSET);
		writeReg(pwmPkg::TOP_OFFSET, 32'h3355_7700, 4'b1110);
		readReg(pwmPkg::TOP_OFFSET);
		writeReg(pwmPkg::TOP_OFFSET, 32'h0000_0042, 4'b0001);
		for (int i = 0; i < OUTPUTS; i++) begin
			writeReg(pwmPkg::COMPARE_BASE + pwmPkg::localAddr_t'(4 * i),
				32'h0000_1130 + i, (i % 2 == 0) ? 4'b0001 : 4'b0010);
		end
		readAllRegisters();

		// accesses that must change nothing
		busAccess(1'b1, {4'h3, pwmPkg::TOP_OFFSET}, 1'b1, 1'b0, 32'h99, 4'hf);
		busAccess(1'b1, deviceAddr(12'h100), 1'b1, 1'b0, 32'h77, 4'hf);
		busAccess(1'b1, deviceAddr(12'h012), 1'b1, 1'b0, 32'h55, 4'hf);
		busAccess(1'b0, deviceAddr(pwmPkg::TOP_OFFSET), 1'b1, 1'b0, 32'h11, 4'hf);
		writeReg(pwmPkg::STATUS_OFFSET, 32'hffff_ffff, 4'hf);
		busAccess(1'b1, {4'h3, pwmPkg::TOP_OFFSET}, 1'b0, 1'b1, '0, '0);
		busAccess(1'b1, deviceAddr(12'h100), 1'b0, 1'b1, '0, '0);
		busAccess(1'b0, deviceAddr(pwmPkg::CONFIG_OFFSET), 1'b0, 1'b1, '0, '0);
		readAllRegisters();

		// scale 0 duty, one compare above top and one at zero
		writeReg(pwmPkg::TOP_OFFSET, 32'd20, 4'hf);
		for (int i = 0; i < 2; i++) begin
			randomWord = {$random(seed)} % 21;
			writeReg(pwmPkg::COMPARE_BASE + pwmPkg::localAddr_t'(4 * i), randomWord, 4'hf);
		end
		writeReg(pwmPkg::COMPARE_BASE + 12'h008, 32'd25, 4'hf);
		writeReg(pwmPkg::COMPARE_BASE + 12'h00c, 32'd0, 4'hf);
		writeReg(pwmPkg::CONFIG_OFFSET, makeConfig(5'd0, 1'b1, 4'hf, 4'h5, 4'h3, 4'h6), 4'hf);
		waitCycles(3 * 21);
		repeat (3) begin
			readReg(pwmPkg::STATUS_OFFSET);
			waitCycles(7);
		end

		// slower scales and a restart by a top write
		for (int s = 1; s <= 2; s++) begin
			writeReg(pwmPkg::TOP_OFFSET, 32'd9, 4'hf);
			writeReg(pwmPkg::CONFIG_OFFSET, makeConfig(5'(s), 1'b1, 4'hf, 4'ha, 4'hc, 4'h9),
				4'hf);
			repeat (6) begin
				readReg(pwmPkg::STATUS_OFFSET);
				waitCycles(5);
			end
			writeReg(pwmPkg::TOP_OFFSET, 32'd6, 4'hf);
			repeat (6) begin
				readReg(pwmPkg::STATUS_OFFSET);
				waitCycles(3);
			end
		end

		// random enable mixes
		repeat (8) begin
			randomWord = $random(seed);
			writeReg(pwmPkg::CONFIG_OFFSET, makeConfig(5'd0, 1'b1, randomWord[3:0],
				randomWord[7:4], randomWord[11:8], randomWord[15:12]), 4'hf);
			waitCycles(12);
		end

		// channel switched off while high gives one fall
		writeReg(pwmPkg::CONFIG_OFFSET, makeConfig(5'd0, 1'b1, 4'hf, 4'hf, 4'h0, 4'hf), 4'hf);
		waitCycles(2);
		writeReg(pwmPkg::CONFIG_OFFSET, makeConfig(5'd0, 1'b1, 4'h0, 4'hf, 4'h0, 4'hf), 4'hf);
		waitCycles(10);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
common/pwmPkg.sv
pwm/pwmChannel.sv
pwm/pwmTimebase.sv
pwm/pwmRegisters.sv
design/pwmPeripheral.sv
tb/pwmPeripheralTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the PWM peripheral testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module pwmPeripheralTb \
	-f verilog.f

# the simulator exits nonzero on a failed check, the log decides the result
status=0
./obj_dir/VpwmPeripheralTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "All checks passed" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed (exit status $status)"
	exit 1
fi
